/* rtl/comm_pkg.sv */
package comm_pkg;

	// ------------------------------
	// data widths
	// ------------------------------
	typedef logic [31:0] word_t;
	typedef logic [29:0] addr_t;
	typedef logic [11:0] count_t;
	typedef logic [2:0] dev_t;

	// ------------------------------
	// link constants
	// ------------------------------
	localparam word_t SYNC_KEY = 32'h4A78B9F2;
	localparam word_t SYNC_XOR = 32'hCD0031F7;
	localparam int PURGE_CYCLES = 20000;
	localparam int PURGE_W = $clog2(PURGE_CYCLES);
	typedef logic [PURGE_W-1:0] purge_t;

	// byte address advance per word
	localparam int WORD_STEP = 4;

	// config word fields
	localparam int CFG_WRITE_BIT = 12;
	localparam int CFG_BURST_BIT = 13;
	localparam int CFG_DEVCFG_BIT = 14;
	localparam int CFG_DEV_LSB = 24;
	localparam int CFG_COUNT_W = 12;

	// ------------------------------
	// state machines
	// ------------------------------
	typedef enum logic [1:0] {
		LINK_PURGE,
		LINK_SYNC,
		LINK_SERVE
	} link_state_e;

	typedef enum logic [2:0] {
		SEQ_TERM,
		SEQ_CONFIG,
		SEQ_ADDRESS,
		SEQ_FETCH,
		SEQ_MEMORY,
		SEQ_SEND,
		SEQ_ACK,
		SEQ_ERROR
	} seq_state_e;

	// one-hot request kind
	typedef enum logic [2:0] {
		REQ_READ = 3'b001,
		REQ_WRITE = 3'b010,
		REQ_DEV = 3'b100
	} req_kind_e;

	typedef struct packed {
		req_kind_e kind;
		addr_t addr;
		word_t data;
		dev_t dev;
	} mem_req_t;

endpackage

/* rtl/comm_link.sv */
`timescale 1ns/1ns

module comm_link import comm_pkg::*; (
	input  logic  clock_i,
	input  logic  resetn_i,
	input  logic  rx_empty_i,
	input  word_t rx_data_i,
	output logic  rx_read_o,
	input  logic  tx_full_i,
	output logic  tx_write_o,
	output word_t tx_data_o,
	output logic  link_ready_o,
	input  logic  get_req_i,
	output logic  get_done_o,
	output word_t get_word_o,
	input  logic  put_req_i,
	input  word_t put_word_i,
	output logic  put_done_o
);

	link_state_e state_q;
	purge_t      purge_cnt_q;
	logic        get_pend_q;
	logic        put_pend_q;
	word_t       put_data_q;
	logic        rx_ok;
	logic        tx_ok;
	logic        sync_take;
	logic        sync_key;

	assign rx_ok = !rx_empty_i;
	assign tx_ok = !tx_full_i;

	// sync words move only when both sides can
	assign sync_take = (state_q == LINK_SYNC) && rx_ok && tx_ok;
	assign sync_key = (rx_data_i == SYNC_KEY);

	// pending requests only exist in serve
	assign get_done_o = get_pend_q && rx_ok;
	assign put_done_o = put_pend_q && tx_ok;
	assign get_word_o = rx_data_i;
	assign link_ready_o = (state_q == LINK_SERVE);

	// ------------------------------
	// FIFO strobes
	// ------------------------------
	assign rx_read_o = ((state_q == LINK_PURGE) && rx_ok) || sync_take || get_done_o;
	assign tx_write_o = (sync_take && !sync_key) || put_done_o;
	assign tx_data_o = (state_q == LINK_SYNC) ? (rx_data_i ^ SYNC_XOR) : put_data_q;

	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			state_q <= LINK_PURGE;
			purge_cnt_q <= purge_t'(PURGE_CYCLES - 1);
			get_pend_q <= 1'b0;
			put_pend_q <= 1'b0;
		end else begin
			case (state_q)
				LINK_PURGE: begin
					// any word restarts the quiet window
					if (rx_ok) begin
						purge_cnt_q <= purge_t'(PURGE_CYCLES - 1);
					end else if (purge_cnt_q != '0) begin
						purge_cnt_q <= purge_cnt_q - 1'b1;
					end else begin
						state_q <= LINK_SYNC;
					end
				end
				LINK_SYNC: begin
					if (sync_take && sync_key) begin
						state_q <= LINK_SERVE;
					end
				end
				LINK_SERVE: begin
					if (get_req_i) begin
						get_pend_q <= 1'b1;
					end else if (get_done_o) begin
						get_pend_q <= 1'b0;
					end
					if (put_req_i) begin
						put_pend_q <= 1'b1;
					end else if (put_done_o) begin
						put_pend_q <= 1'b0;
					end
				end
				default: begin
					state_q <= LINK_PURGE;
				end
			endcase
		end
	end

	// outgoing word held until the TX FIFO takes it
	always_ff @(posedge clock_i) begin
		if (put_req_i) begin
			put_data_q <= put_word_i;
		end
	end

	// at most one get and one put open at a time
	a_get_single: assert property (
		@(posedge clock_i) disable iff (!resetn_i) get_req_i |-> !get_pend_q
	);

	a_put_single: assert property (
		@(posedge clock_i) disable iff (!resetn_i) put_req_i |-> !put_pend_q
	);

endmodule

/* rtl/comm_mem_port.sv */
`timescale 1ns/1ns

module comm_mem_port import comm_pkg::*; (
	input  logic     clock_i,
	input  logic     resetn_i,
	input  logic     mem_go_i,
	input  mem_req_t mem_req_i,
	output logic     mem_done_o,
	output word_t    mem_rdata_o,
	input  logic     ready_i,
	input  logic     done_i,
	input  word_t    data_i,
	output logic     req_o,
	output logic     rw_o,
	output addr_t    add_o,
	output word_t    data_o,
	output logic     clear_o,
	output dev_t     reqdev_o
);

	typedef enum logic [1:0] {
		MEM_IDLE,
		MEM_WAIT_READY,
		MEM_WAIT_DONE
	} mem_state_e;

	mem_state_e state_q;
	mem_req_t   req_q;

	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			state_q <= MEM_IDLE;
			req_o <= 1'b0;
			rw_o <= 1'b0;
			clear_o <= 1'b0;
			mem_done_o <= 1'b0;
			reqdev_o <= '0;
			add_o <= '0;
			data_o <= '0;
		end else begin
			// strobes last one cycle
			req_o <= 1'b0;
			rw_o <= 1'b0;
			clear_o <= 1'b0;
			mem_done_o <= 1'b0;
			reqdev_o <= '0;
			case (state_q)
				MEM_IDLE: begin
					if (mem_go_i && mem_req_i.kind == REQ_DEV) begin
						// device config goes out at once
						req_o <= 1'b1;
						reqdev_o <= mem_req_i.dev;
						data_o <= mem_req_i.data;
						mem_done_o <= 1'b1;
					end else if (mem_go_i) begin
						state_q <= MEM_WAIT_READY;
					end
				end
				MEM_WAIT_READY: begin
					if (ready_i) begin
						req_o <= 1'b1;
						rw_o <= (req_q.kind == REQ_WRITE);
						add_o <= req_q.addr;
						if (req_q.kind == REQ_WRITE) begin
							data_o <= req_q.data;
						end
						state_q <= MEM_WAIT_DONE;
					end
				end
				MEM_WAIT_DONE: begin
					if (done_i) begin
						clear_o <= 1'b1;
						mem_done_o <= 1'b1;
						state_q <= MEM_IDLE;
					end
				end
				default: begin
					state_q <= MEM_IDLE;
				end
			endcase
		end
	end

	// request and read data payload
	always_ff @(posedge clock_i) begin
		if (mem_go_i) begin
			req_q <= mem_req_i;
		end
		if (state_q == MEM_WAIT_DONE && done_i && req_q.kind == REQ_READ) begin
			mem_rdata_o <= data_i;
		end
	end

	a_req_clear_apart: assert property (
		@(posedge clock_i) disable iff (!resetn_i) !(req_o && clear_o)
	);

endmodule

/* rtl/comm_sequencer.sv */
`timescale 1ns/1ns

module comm_sequencer import comm_pkg::*; (
	input  logic     clock_i,
	input  logic     resetn_i,
	input  logic     link_ready_i,
	output logic     get_req_o,
	input  logic     get_done_i,
	input  word_t    get_word_i,
	output logic     put_req_o,
	output word_t    put_word_o,
	input  logic     put_done_i,
	output logic     mem_go_o,
	output mem_req_t mem_req_o,
	input  logic     mem_done_i,
	input  word_t    mem_rdata_i,
	output logic     exception_o
);

	seq_state_e state_q;
	logic       busy_q;
	logic       is_write_q;
	logic       is_dev_q;
	count_t     count_q;
	addr_t      addr_q;
	word_t      data_q;
	dev_t       dev_q;
	count_t     cfg_count;
	logic       last_word;
	logic       need_get;
	logic       need_put;
	logic       need_mem;

	assign last_word = (count_q == count_t'(1));
	assign exception_o = (state_q == SEQ_ERROR);

	// which exchange the current state waits on
	assign need_get = (state_q == SEQ_TERM) || (state_q == SEQ_CONFIG) ||
		(state_q == SEQ_ADDRESS) || (state_q == SEQ_FETCH);
	assign need_put = (state_q == SEQ_SEND) || (state_q == SEQ_ACK);
	assign need_mem = (state_q == SEQ_MEMORY);

	// word count from config, zero means one
	always_comb begin
		cfg_count = count_t'(1);
		if (get_word_i[CFG_BURST_BIT] && get_word_i[CFG_COUNT_W-1:0] != '0) begin
			cfg_count = get_word_i[CFG_COUNT_W-1:0];
		end
	end

	always_comb begin
		mem_req_o.kind = REQ_READ;
		if (is_dev_q) begin
			mem_req_o.kind = REQ_DEV;
		end else if (is_write_q) begin
			mem_req_o.kind = REQ_WRITE;
		end
		mem_req_o.addr = addr_q;
		mem_req_o.data = data_q;
		mem_req_o.dev = dev_q;
	end

	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			state_q <= SEQ_TERM;
			busy_q <= 1'b0;
			get_req_o <= 1'b0;
			put_req_o <= 1'b0;
			mem_go_o <= 1'b0;
			is_write_q <= 1'b0;
			is_dev_q <= 1'b0;
			count_q <= count_t'(1);
		end else begin
			get_req_o <= 1'b0;
			put_req_o <= 1'b0;
			mem_go_o <= 1'b0;

			// ------------------------------
			// issue one request at a time
			// ------------------------------
			if (!busy_q && link_ready_i) begin
				get_req_o <= need_get;
				put_req_o <= need_put;
				mem_go_o <= need_mem;
				busy_q <= need_get || need_put || need_mem;
				if (need_put) begin
					put_word_o <= (state_q == SEQ_ACK) ? '0 : data_q;
				end
			end

			// ------------------------------
			// completions
			// ------------------------------
			case (state_q)
				SEQ_TERM: begin
					if (get_done_i) begin
						busy_q <= 1'b0;
						state_q <= (get_word_i == '0) ? SEQ_CONFIG : SEQ_ERROR;
					end
				end
				SEQ_CONFIG: begin
					if (get_done_i) begin
						busy_q <= 1'b0;
						is_write_q <= get_word_i[CFG_WRITE_BIT];
						is_dev_q <= get_word_i[CFG_DEVCFG_BIT];
						dev_q <= get_word_i[CFG_DEV_LSB +: $bits(dev_t)];
						data_q <= word_t'(get_word_i[1:0]);
						count_q <= cfg_count;
						state_q <= get_word_i[CFG_DEVCFG_BIT] ? SEQ_MEMORY : SEQ_ADDRESS;
					end
				end
				SEQ_ADDRESS: begin
					if (get_done_i) begin
						busy_q <= 1'b0;
						addr_q <= get_word_i[$bits(addr_t)-1:0];
						state_q <= is_write_q ? SEQ_FETCH : SEQ_MEMORY;
					end
				end
				SEQ_FETCH: begin
					if (get_done_i) begin
						busy_q <= 1'b0;
						data_q <= get_word_i;
						state_q <= SEQ_MEMORY;
					end
				end
				SEQ_MEMORY: begin
					if (mem_done_i) begin
						busy_q <= 1'b0;
						if (is_dev_q) begin
							state_q <= SEQ_ACK;
						end else if (!is_write_q) begin
							data_q <= mem_rdata_i;
							state_q <= SEQ_SEND;
						end else begin
							addr_q <= addr_q + addr_t'(WORD_STEP);
							count_q <= count_q - 1'b1;
							state_q <= last_word ? SEQ_ACK : SEQ_FETCH;
						end
					end
				end
				SEQ_SEND: begin
					// reads end without an acknowledge
					if (put_done_i) begin
						busy_q <= 1'b0;
						addr_q <= addr_q + addr_t'(WORD_STEP);
						count_q <= count_q - 1'b1;
						state_q <= last_word ? SEQ_TERM : SEQ_MEMORY;
					end
				end
				SEQ_ACK: begin
					if (put_done_i) begin
						busy_q <= 1'b0;
						state_q <= SEQ_TERM;
					end
				end
				default: begin
					// error holds until reset
					state_q <= SEQ_ERROR;
				end
			endcase
		end
	end

endmodule

/* rtl/comm_controller.sv */
`timescale 1ns/1ns

module comm_controller import comm_pkg::*; (
	input  logic  clock_i,
	input  logic  resetn_i,
	input  logic  rx_empty_i,
	input  word_t rx_data_i,
	output logic  rx_read_o,
	input  logic  tx_full_i,
	output logic  tx_write_o,
	output word_t tx_data_o,
	input  logic  ready_i,
	input  logic  done_i,
	input  word_t data_i,
	output logic  req_o,
	output logic  rw_o,
	output addr_t add_o,
	output word_t data_o,
	output logic  clear_o,
	output dev_t  reqdev_o,
	output logic  exception_o
);

	// link service handshake
	logic     link_ready;
	logic     get_req;
	logic     get_done;
	word_t    get_word;
	logic     put_req;
	word_t    put_word;
	logic     put_done;

	// memory port handshake
	logic     mem_go;
	mem_req_t mem_req;
	logic     mem_done;
	word_t    mem_rdata;

	comm_link u_link (
		.clock_i      (clock_i),
		.resetn_i     (resetn_i),
		.rx_empty_i   (rx_empty_i),
		.rx_data_i    (rx_data_i),
		.rx_read_o    (rx_read_o),
		.tx_full_i    (tx_full_i),
		.tx_write_o   (tx_write_o),
		.tx_data_o    (tx_data_o),
		.link_ready_o (link_ready),
		.get_req_i    (get_req),
		.get_done_o   (get_done),
		.get_word_o   (get_word),
		.put_req_i    (put_req),
		.put_word_i   (put_word),
		.put_done_o   (put_done)
	);

	comm_sequencer u_seq (
		.clock_i      (clock_i),
		.resetn_i     (resetn_i),
		.link_ready_i (link_ready),
		.get_req_o    (get_req),
		.get_done_i   (get_done),
		.get_word_i   (get_word),
		.put_req_o    (put_req),
		.put_word_o   (put_word),
		.put_done_i   (put_done),
		.mem_go_o     (mem_go),
		.mem_req_o    (mem_req),
		.mem_done_i   (mem_done),
		.mem_rdata_i  (mem_rdata),
		.exception_o  (exception_o)
	);

	comm_mem_port u_mem (
		.clock_i     (clock_i),
		.resetn_i    (resetn_i),
		.mem_go_i    (mem_go),
		.mem_req_i   (mem_req),
		.mem_done_o  (mem_done),
		.mem_rdata_o (mem_rdata),
		.ready_i     (ready_i),
		.done_i      (done_i),
		.data_i      (data_i),
		.req_o       (req_o),
		.rw_o        (rw_o),
		.add_o       (add_o),
		.data_o      (data_o),
		.clear_o     (clear_o),
		.reqdev_o    (reqdev_o)
	);

endmodule

/* dv/tb_clock_gen.sv */
`timescale 1ns/1ns

module tb_clock_gen (
	output logic clock_o,
	output logic resetn_o
);

	localparam int HALF_PERIOD = 20;
	localparam int RESET_CYCLES = 5;

	initial begin
		clock_o = 1'b0;
		forever #HALF_PERIOD clock_o = ~clock_o;
	end

	// reset released on a rising edge
	initial begin
		resetn_o <= 1'b0;
		repeat (RESET_CYCLES) @(posedge clock_o);
		resetn_o <= 1'b1;
	end

endmodule

/* dv/tb_checker.sv */
`timescale 1ns/1ns

module tb_checker import comm_pkg::*; (
	input logic  clock_i,
	input logic  resetn_i,
	input logic  tx_write_i,
	input word_t tx_data_i,
	input logic  req_i,
	input logic  rw_i,
	input addr_t add_i,
	input word_t data_i,
	input dev_t  reqdev_i,
	input logic  clear_i,
	input logic  done_i,
	input logic  exception_i,
	input logic  exc_allowed_i
);

	word_t    exp_tx[$];
	string    tx_test[$];
	mem_req_t exp_req[$];
	string    req_test[$];
	int       errors = 0;
	int       tx_checked = 0;
	int       req_checked = 0;
	logic     exc_seen = 1'b0;
	logic     mem_open = 1'b0;
	logic     done_q = 1'b0;

	task automatic expect_tx(input word_t w, input string name);
		exp_tx.push_back(w);
		tx_test.push_back(name);
	endtask

	task automatic expect_req(input mem_req_t r, input string name);
		exp_req.push_back(r);
		req_test.push_back(name);
	endtask

	function automatic int outstanding();
		return exp_tx.size() + exp_req.size() + int'(mem_open);
	endfunction

	task automatic check_tx();
		word_t e;
		string name;
		e = exp_tx.pop_front();
		name = tx_test.pop_front();
		tx_checked++;
		if (tx_data_i !== e) begin
			$display("FAILED %s: tx word expected %h, actual %h", name, e, tx_data_i);
			errors++;
		end
	endtask

	// only the fields that matter for each request kind, as {rw, add, data, dev}
	task automatic check_req();
		mem_req_t e;
		string name;
		logic [65:0] want;
		logic [65:0] got;
		e = exp_req.pop_front();
		name = req_test.pop_front();
		req_checked++;
		if (e.kind != REQ_DEV) begin
			mem_open = 1'b1;
		end
		case (e.kind)
			REQ_WRITE: begin
				want = {1'b1, e.addr, e.data, 3'b000};
				got = {rw_i, add_i, data_i, reqdev_i};
			end
			REQ_DEV: begin
				want = {1'b0, addr_t'(0), e.data, e.dev};
				got = {rw_i, addr_t'(0), data_i, reqdev_i};
			end
			default: begin
				want = {1'b0, e.addr, 32'h0, 3'b000};
				got = {rw_i, add_i, 32'h0, reqdev_i};
			end
		endcase
		if (got !== want) begin
			$display("FAILED %s: request expected %h, actual %h", name, want, got);
			errors++;
		end
	endtask

	// ------------------------------
	// port monitor
	// ------------------------------
	always @(posedge clock_i) begin
		if (resetn_i) begin
			if (tx_write_i && exp_tx.size() == 0) begin
				$display("unexpected word %h written to the TX FIFO", tx_data_i);
				errors++;
			end else if (tx_write_i) begin
				check_tx();
			end
			// clear_o answers the done_i of an open read or write
			if (mem_open && done_q) begin
				if (!clear_i) begin
					$display("clear_o missing after done_i of a memory request");
					errors++;
				end
				mem_open = 1'b0;
			end else if (clear_i) begin
				$display("clear_o pulsed with no finished memory request");
				errors++;
			end
			if (req_i && exp_req.size() == 0) begin
				$display("unexpected memory request at address %h", add_i);
				errors++;
			end else if (req_i) begin
				check_req();
			end
			if (exception_i && !exc_allowed_i && !exc_seen) begin
				$display("exception_o went high during a valid command");
				errors++;
			end
			if (exc_seen && !exception_i) begin
				$display("exception_o dropped before reset");
				errors++;
			end
			exc_seen = exception_i;
			done_q = done_i;
		end
	end

endmodule

/* dv/tb_top.sv */
`timescale 1ns/1ns

module tb_top import comm_pkg::*; ();

	localparam word_t SEED = 32'hf551a41a;
	localparam int CLK_PERIOD = 40;
	localparam int N_PURGE = 6;
	localparam int N_SYNC = 4;
	localparam int N_RANDOM = 24;
	localparam int CMD_WRITE = 0;
	localparam int CMD_READ = 1;
	localparam int CMD_DEV = 2;
	// terminator, config, address and up to 8 data words
	localparam int MAX_CMD_WORDS = 11;
	localparam int CYCLES_PER_WORD = 40;
	localparam int WATCHDOG_CYCLES = PURGE_CYCLES + 500 +
		CYCLES_PER_WORD * (N_PURGE + N_SYNC + (N_RANDOM + 4) * MAX_CMD_WORDS);

	logic  clock;
	logic  resetn;
	logic  rx_empty = 1'b1;
	word_t rx_data = '0;
	logic  tx_full = 1'b0;
	logic  ready = 1'b0;
	logic  done = 1'b0;
	word_t mem_rdata = '0;
	logic  rx_read;
	logic  tx_write;
	word_t tx_data;
	logic  req;
	logic  rw;
	addr_t add;
	word_t mem_wdata;
	logic  clear;
	dev_t  reqdev;
	logic  exception;
	logic  exc_allowed;

	word_t rx_q[$];
	int    rx_rd;
	word_t mem [0:255];
	word_t ref_mem [0:255];
	word_t stim_rng;
	word_t fifo_rng;
	word_t mem_rng;
	int    done_wait;
	string test_name;

	tb_clock_gen u_clk (
		.clock_o  (clock),
		.resetn_o (resetn)
	);

	comm_controller u_dut (
		.clock_i     (clock),
		.resetn_i    (resetn),
		.rx_empty_i  (rx_empty),
		.rx_data_i   (rx_data),
		.rx_read_o   (rx_read),
		.tx_full_i   (tx_full),
		.tx_write_o  (tx_write),
		.tx_data_o   (tx_data),
		.ready_i     (ready),
		.done_i      (done),
		.data_i      (mem_rdata),
		.req_o       (req),
		.rw_o        (rw),
		.add_o       (add),
		.data_o      (mem_wdata),
		.clear_o     (clear),
		.reqdev_o    (reqdev),
		.exception_o (exception)
	);

	tb_checker u_chk (
		.clock_i       (clock),
		.resetn_i      (resetn),
		.tx_write_i    (tx_write),
		.tx_data_i     (tx_data),
		.req_i         (req),
		.rw_i          (rw),
		.add_i         (add),
		.data_i        (mem_wdata),
		.reqdev_i      (reqdev),
		.clear_i       (clear),
		.done_i        (done),
		.exception_i   (exception),
		.exc_allowed_i (exc_allowed)
	);

	function automatic word_t xorshift32(input word_t x);
		word_t y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic word_t rand_word();
		stim_rng = xorshift32(stim_rng);
		return stim_rng;
	endfunction

	function automatic word_t fill_word(input int idx);
		return {8'(idx), ~8'(idx), 8'(idx) ^ 8'h5a, 8'hc3};
	endfunction

	// ------------------------------
	// link FIFO and memory models
	// ------------------------------
	always @(posedge clock) begin
		if (!resetn) begin
			fifo_rng = xorshift32(SEED);
			rx_rd = 0;
		end else begin
			fifo_rng = xorshift32(fifo_rng);
			if (rx_read && rx_rd < rx_q.size()) begin
				rx_rd++;
			end
		end
		rx_empty <= (rx_rd >= rx_q.size()) || (fifo_rng[2:0] == 3'd0);
		rx_data <= (rx_rd < rx_q.size()) ? rx_q[rx_rd] : '0;
		tx_full <= (fifo_rng[5:3] == 3'd0);
	end

	always @(posedge clock) begin
		if (!resetn) begin
			mem_rng = xorshift32(xorshift32(SEED));
			done_wait = -1;
			for (int i = 0; i < 256; i++) begin
				mem[i] <= fill_word(i);
			end
		end else begin
			mem_rng = xorshift32(mem_rng);
			if (req) begin
				// done follows 0 to 3 cycles later
				done_wait = int'(mem_rng[5:4]);
				if (rw) begin
					mem[add[9:2]] <= mem_wdata;
				end else begin
					mem_rdata <= mem[add[9:2]];
				end
			end
		end
		ready <= resetn && (mem_rng[1:0] != 2'd0);
		done <= (done_wait == 0);
		if (done_wait >= 0) begin
			done_wait = done_wait - 1;
		end
	end

	// ------------------------------
	// stimulus and expected values
	// ------------------------------
	task automatic push_word(input word_t w);
		rx_q.push_back(w);
	endtask

	task automatic send_command(input int kind, input word_t start);
		word_t cfg;
		word_t w;
		addr_t addr;
		mem_req_t r;
		int n;
		int i;
		cfg = rand_word();
		cfg[CFG_DEVCFG_BIT] = (kind == CMD_DEV);
		cfg[CFG_WRITE_BIT] = (kind == CMD_WRITE);
		cfg[CFG_COUNT_W-1:0] = count_t'(rand_word() % 9);
		n = (cfg[CFG_BURST_BIT] && cfg[CFG_COUNT_W-1:0] != '0) ? int'(cfg[CFG_COUNT_W-1:0]) : 1;
		push_word('0);
		push_word(cfg);
		if (kind == CMD_DEV) begin
			r.kind = REQ_DEV;
			r.addr = '0;
			r.data = word_t'(cfg[1:0]);
			r.dev = cfg[CFG_DEV_LSB +: 3];
			u_chk.expect_req(r, test_name);
			u_chk.expect_tx('0, test_name);
		end else begin
			start[1:0] = 2'b00;
			push_word(start);
			addr = start[29:0];
			for (i = 0; i < n; i++) begin
				r.addr = addr;
				r.dev = '0;
				r.data = '0;
				r.kind = REQ_READ;
				if (kind == CMD_WRITE) begin
					w = rand_word();
					push_word(w);
					r.kind = REQ_WRITE;
					r.data = w;
					ref_mem[addr[9:2]] = w;
				end else begin
					u_chk.expect_tx(ref_mem[addr[9:2]], test_name);
				end
				u_chk.expect_req(r, test_name);
				addr = addr + addr_t'(WORD_STEP);
			end
			// writes close with a zero acknowledge
			if (kind == CMD_WRITE) begin
				u_chk.expect_tx('0, test_name);
			end
		end
	endtask

	task automatic wait_all_checked();
		while (rx_rd != rx_q.size() || u_chk.outstanding() != 0) begin
			@(negedge clock);
		end
	endtask

	task automatic finish_run(input bit timed_out);
		int errs;
		errs = u_chk.errors + (timed_out ? 1 : 0);
		$display("run ended with %0d errors, %0d tx words and %0d requests checked",
			errs, u_chk.tx_checked, u_chk.req_checked);
		if (errs == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	endtask

	initial begin
		word_t w;
		word_t start;
		exc_allowed = 1'b0;
		stim_rng = SEED;
		test_name = "purge";
		for (int i = 0; i < 256; i++) begin
			ref_mem[i] = fill_word(i);
		end
		wait (resetn === 1'b1);
		@(negedge clock);

		// drained without any echo
		for (int i = 0; i < N_PURGE; i++) begin
			push_word(rand_word());
		end
		wait_all_checked();
		repeat (PURGE_CYCLES + 8) @(negedge clock);

		test_name = "sync";
		for (int i = 0; i < N_SYNC; i++) begin
			w = rand_word();
			if (w == SYNC_KEY) begin
				w = ~w;
			end
			push_word(w);
			u_chk.expect_tx(w ^ SYNC_XOR, test_name);
		end
		push_word(SYNC_KEY);

		// write then read back the same range
		start = rand_word();
		test_name = "write";
		send_command(CMD_WRITE, start);
		test_name = "read";
		send_command(CMD_READ, start);
		test_name = "devcfg";
		send_command(CMD_DEV, '0);
		test_name = "random";
		for (int i = 0; i < N_RANDOM; i++) begin
			send_command(int'(rand_word() % 3), rand_word());
		end
		wait_all_checked();

		// ------------------------------
		// bad terminator, then silence
		// ------------------------------
		test_name = "error";
		exc_allowed = 1'b1;
		push_word(rand_word() | 32'h1);
		while (exception !== 1'b1) begin
			@(negedge clock);
		end
		push_word('0);
		push_word(32'h0000_1000);
		push_word(32'h0000_0040);
		push_word(rand_word());
		repeat (50) @(negedge clock);
		finish_run(1'b0);
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("timeout: run still busy after %0d clock cycles", WATCHDOG_CYCLES);
		finish_run(1'b1);
	end

endmodule

/* compile.f */
rtl/comm_pkg.sv
rtl/comm_link.sv
rtl/comm_mem_port.sv
rtl/comm_sequencer.sv
rtl/comm_controller.sv
dv/tb_clock_gen.sv
dv/tb_checker.sv
dv/tb_top.sv

/* Makefile */
# Verilator build and run for the host-link controller testbench

VERILATOR ?= verilator
TOP       ?= tb_top
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# the log decides the result
run: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)
	@if grep -q '>>> FAIL' $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q '>>> PASS' $(LOG); then echo "simulation ended without a verdict"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
